/* Makefile */
TOP := pmu_loader_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f pmu_loader.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f pmu_loader.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

/* pmu_loader.f */
src/pmu_pkg.sv
src/cfg_stream_if.sv
src/jtag_shift_in.sv
src/bitstream_checker.sv
src/config_chain_driver.sv
src/pmu_loader.sv
tb/pmu_loader_properties.sv
tb/pmu_loader_tb.sv

/* src/bitstream_checker.sv */
`timescale 1ns/1ps

module bitstream_checker #(
    parameter int WORDS = 4
) (
    input  logic            tck_i,
    input  logic            rst_i,
    input  logic            word_valid_i,
    input  pmu_pkg::word_t  word_i,

    input  pmu_pkg::word_t  mem_data_i,
    output pmu_pkg::word_t  mem_data_o,
    output pmu_pkg::addr_t  mem_address_o,
    output logic            mem_we_o,

    output logic            locked_o,

    cfg_stream_if.check     stream
);

    localparam logic [1:0] ST_RECV = 2'd0;
    localparam logic [1:0] ST_READ = 2'd1;  // Driver owns the NVM address
    localparam logic [1:0] ST_DONE = 2'd2;
    localparam logic [1:0] ST_LOCK = 2'd3;

    logic [1:0]     state;
    pmu_pkg::addr_t word_cnt;
    pmu_pkg::addr_t wr_addr;
    pmu_pkg::word_t crc_q;
    logic           start_q;

    // One data word through the CRC LSB first
    function automatic pmu_pkg::word_t crc_word(input pmu_pkg::word_t crc,
                                                input pmu_pkg::word_t data);
        pmu_pkg::word_t c;
        c = crc;
        for (int i = 0; i < pmu_pkg::WORD_W; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ pmu_pkg::CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge tck_i) begin
        if (rst_i) begin
            state    <= ST_RECV;
            word_cnt <= '0;
            wr_addr  <= '0;
            crc_q    <= pmu_pkg::CRC_INIT;
            mem_we_o <= 1'b0;
            start_q  <= 1'b0;
            locked_o <= 1'b0;
        end else begin
            mem_we_o <= 1'b0;
            start_q  <= 1'b0;
            case (state)
                ST_RECV: begin
                    if (word_valid_i) begin
                        if (word_cnt < pmu_pkg::addr_t'(WORDS)) begin
                            mem_we_o <= 1'b1;
                            wr_addr  <= word_cnt;
                            crc_q    <= crc_word(crc_q, word_i);
                            word_cnt <= word_cnt + 1'b1;
                        end else if ((crc_q ^ pmu_pkg::CRC_XOROUT) == word_i) begin
                            start_q <= 1'b1;
                            state   <= ST_READ;
                        end else begin
                            locked_o <= 1'b1;  // Held until reset
                            state    <= ST_LOCK;
                        end
                    end
                end
                ST_READ: begin
                    if (stream.done) begin
                        state <= ST_DONE;
                    end
                end
                default: ;  // Words ignored once done or locked
            endcase
        end
    end

    // Write data rides along with the write strobe
    always_ff @(posedge tck_i) begin
        if (state == ST_RECV && word_valid_i) begin
            mem_data_o <= word_i;
        end
    end

    assign mem_address_o  = (state == ST_READ || state == ST_DONE) ? stream.rd_addr : wr_addr;
    assign stream.start   = start_q;
    assign stream.rd_data = mem_data_i;

endmodule

/* src/cfg_stream_if.sv */
`timescale 1ns/1ps

interface cfg_stream_if;

    logic            start;    // One-cycle pulse on CRC match
    pmu_pkg::addr_t  rd_addr;  // NVM read address from the driver
    pmu_pkg::word_t  rd_data;  // NVM data, one cycle after rd_addr
    logic            done;     // Chain fully loaded

    modport check (
        output start,
        output rd_data,
        input  rd_addr,
        input  done
    );

    modport driver (
        input  start,
        input  rd_data,
        output rd_addr,
        output done
    );

endinterface

/* src/config_chain_driver.sv */
`timescale 1ns/1ps

module config_chain_driver #(
    parameter int WORDS = 4
) (
    input  logic         tck_i,
    input  logic         rst_i,
    input  logic         ccff_tail_i,
    cfg_stream_if.driver stream,
    output logic         progclk_o,
    output logic         data_o,
    output logic         preset_o,
    output logic         fpga_rst_o,
    output logic         fpga_clk_en_o,
    output logic         core_ready_o,
    output logic         td_o
);

    localparam int CNT_W = $clog2(pmu_pkg::WORD_W);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_FETCH  = 2'd1;
    localparam logic [1:0] ST_SHIFT  = 2'd2;
    localparam logic [1:0] ST_FINISH = 2'd3;

    logic [1:0]       state;
    logic             phase;    // Fetch wait, or progclk half
    logic [CNT_W-1:0] bit_cnt;
    pmu_pkg::addr_t   rd_addr;
    pmu_pkg::word_t   shift_q;
    logic             fabric_rst;
    logic             done_q;

    always_ff @(posedge tck_i) begin
        if (rst_i) begin
            state         <= ST_IDLE;
            phase         <= 1'b0;
            bit_cnt       <= '0;
            rd_addr       <= '0;
            progclk_o     <= 1'b0;
            data_o        <= 1'b0;
            fabric_rst    <= 1'b1;
            fpga_clk_en_o <= 1'b0;
            done_q        <= 1'b0;
            core_ready_o  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (stream.start) begin
                        state <= ST_FETCH;
                        phase <= 1'b0;
                    end
                end
                ST_FETCH: begin
                    if (!phase) begin
                        phase <= 1'b1;  // NVM read latency
                    end else begin
                        shift_q <= stream.rd_data;
                        data_o  <= stream.rd_data[0];
                        bit_cnt <= '0;
                        phase   <= 1'b0;
                        state   <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    if (!phase) begin
                        progclk_o <= 1'b1;
                        phase     <= 1'b1;
                    end else begin
                        progclk_o <= 1'b0;
                        phase     <= 1'b0;
                        if (bit_cnt == CNT_W'(pmu_pkg::WORD_W - 1)) begin
                            if (rd_addr == pmu_pkg::addr_t'(WORDS - 1)) begin
                                state         <= ST_FINISH;
                                done_q        <= 1'b1;
                                fabric_rst    <= 1'b0;
                                fpga_clk_en_o <= 1'b1;
                            end else begin
                                rd_addr <= rd_addr + 1'b1;
                                state   <= ST_FETCH;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            shift_q <= shift_q >> 1;
                            data_o  <= shift_q[1];
                        end
                    end
                end
                ST_FINISH: core_ready_o <= 1'b1;  // One cycle after done
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Chain tail readback
    always_ff @(posedge tck_i) begin
        if (rst_i) begin
            td_o <= 1'b0;
        end else if (progclk_o) begin
            td_o <= ccff_tail_i;
        end
    end

    assign preset_o       = fabric_rst;
    assign fpga_rst_o     = fabric_rst;
    assign stream.rd_addr = rd_addr;
    assign stream.done    = done_q;

endmodule

/* src/jtag_shift_in.sv */
`timescale 1ns/1ps

module jtag_shift_in (
    input  logic           tck_i,
    input  logic           rst_i,
    input  logic           en_i,
    input  logic           tdi_i,
    output logic           word_valid_o,
    output pmu_pkg::word_t word_o
);

    localparam int CNT_W = $clog2(pmu_pkg::WORD_W);

    pmu_pkg::word_t   shift_q;
    logic [CNT_W-1:0] bit_cnt;

    // Bit counter and word strobe
    always_ff @(posedge tck_i) begin
        if (rst_i) begin
            bit_cnt      <= '0;
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= 1'b0;
            if (en_i) begin
                bit_cnt <= bit_cnt + 1'b1;  // Wraps after the last bit
                if (bit_cnt == CNT_W'(pmu_pkg::WORD_W - 1)) begin
                    word_valid_o <= 1'b1;
                end
            end
        end
    end

    // Right shift so the first bit ends up in bit 0
    always_ff @(posedge tck_i) begin
        if (en_i) begin
            shift_q <= {tdi_i, shift_q[pmu_pkg::WORD_W-1:1]};
            if (bit_cnt == CNT_W'(pmu_pkg::WORD_W - 1)) begin
                word_o <= {tdi_i, shift_q[pmu_pkg::WORD_W-1:1]};
            end
        end
    end

endmodule

/* src/pmu_loader.sv */
`timescale 1ns/1ps

module pmu_loader #(
    parameter int WORDS = 4
) (
    // JTAG side
    input  logic           tck_i,
    input  logic           rst_i,
    input  logic           en_i,
    input  logic           tdi_i,
    output logic           td_o,

    // NVM
    input  pmu_pkg::word_t mem_data_i,
    output pmu_pkg::word_t mem_data_o,
    output pmu_pkg::addr_t mem_address_o,
    output logic           mem_we_o,

    // Fabric configuration chain
    output logic           progclk_o,
    output logic           preset_o,
    output logic           fpga_rst_o,
    output logic           fpga_clk_en_o,
    output logic           data_o,
    input  logic           ccff_tail_i,

    output logic           core_ready_o,
    output logic           locked_o
);

    logic           word_valid;
    pmu_pkg::word_t word;

    cfg_stream_if stream_ ();

    jtag_shift_in jtag_shift_in_ (
        .tck_i        (tck_i),
        .rst_i        (rst_i),
        .en_i         (en_i),
        .tdi_i        (tdi_i),
        .word_valid_o (word_valid),
        .word_o       (word)
    );

    bitstream_checker #(.WORDS(WORDS)) bitstream_checker_ (
        .tck_i         (tck_i),
        .rst_i         (rst_i),
        .word_valid_i  (word_valid),
        .word_i        (word),
        .mem_data_i    (mem_data_i),
        .mem_data_o    (mem_data_o),
        .mem_address_o (mem_address_o),
        .mem_we_o      (mem_we_o),
        .locked_o      (locked_o),
        .stream        (stream_.check)
    );

    config_chain_driver #(.WORDS(WORDS)) config_chain_driver_ (
        .tck_i         (tck_i),
        .rst_i         (rst_i),
        .ccff_tail_i   (ccff_tail_i),
        .stream        (stream_.driver),
        .progclk_o     (progclk_o),
        .data_o        (data_o),
        .preset_o      (preset_o),
        .fpga_rst_o    (fpga_rst_o),
        .fpga_clk_en_o (fpga_clk_en_o),
        .core_ready_o  (core_ready_o),
        .td_o          (td_o)
    );

endmodule

/* src/pmu_pkg.sv */
package pmu_pkg;

    // Word and NVM address widths
    localparam int WORD_W = 32;
    localparam int ADDR_W = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Reflected CRC-32 shifted LSB first
    localparam word_t CRC_POLY   = 32'hEDB8_8320;
    localparam word_t CRC_INIT   = 32'hFFFF_FFFF;
    localparam word_t CRC_XOROUT = 32'hFFFF_FFFF;

endpackage

/* tb/pmu_loader_properties.sv */
`timescale 1ns/1ps

module pmu_loader_properties (
    input logic tck_i,
    input logic rst_i,
    input logic progclk_i,
    input logic mem_we_i,
    input logic locked_i,
    input logic core_ready_i,
    input logic fpga_clk_en_i,
    input logic fpga_rst_i
);

    int unsigned assert_fails = 0;  // Read by the testbench at the end

    // Every progclk pulse is one cycle wide
    progclk_single: assert property (@(posedge tck_i) disable iff (rst_i)
        progclk_i |=> !progclk_i)
        else begin
            $error("progclk_o stayed high for two cycles");
            assert_fails++;
        end

    no_write_locked: assert property (@(posedge tck_i) disable iff (rst_i)
        !(mem_we_i && locked_i))
        else begin
            $error("NVM write while locked_o is high");
            assert_fails++;
        end

    ready_xor_locked: assert property (@(posedge tck_i) disable iff (rst_i)
        !(core_ready_i && locked_i))
        else begin
            $error("core_ready_o and locked_o both high");
            assert_fails++;
        end

    clk_en_out_of_reset: assert property (@(posedge tck_i) disable iff (rst_i)
        fpga_clk_en_i |-> !fpga_rst_i)
        else begin
            $error("fabric clock enabled while fabric in reset");
            assert_fails++;
        end

endmodule

bind pmu_loader pmu_loader_properties props_ (
    .tck_i         (tck_i),
    .rst_i         (rst_i),
    .progclk_i     (progclk_o),
    .mem_we_i      (mem_we_o),
    .locked_i      (locked_o),
    .core_ready_i  (core_ready_o),
    .fpga_clk_en_i (fpga_clk_en_o),
    .fpga_rst_i    (fpga_rst_o)
);

/* tb/pmu_loader_tb.sv */
`timescale 1ns/1ps

module pmu_loader_tb;

    localparam int          WORDS        = 4;
    localparam int          NROWS        = 8;
    localparam int          CLK_PERIOD   = 10;
    localparam int          PAUSE_CYCLES = 3;
    localparam logic [31:0] SEED         = 32'h26b97fc9;

    // Budget per row in cycles
    localparam longint ROW_CYCLES = 5 * 32 + WORDS * 66 + 60;
    localparam longint LIMIT_NS   = NROWS * ROW_CYCLES * CLK_PERIOD;

    logic           tck_i;
    logic           rst_i;
    logic           en_i;
    logic           tdi_i;
    pmu_pkg::word_t mem_data_i = '0;
    logic           ccff_tail_i;
    logic           td_o;
    pmu_pkg::word_t mem_data_o;
    pmu_pkg::addr_t mem_address_o;
    logic           mem_we_o;
    logic           progclk_o;
    logic           preset_o;
    logic           fpga_rst_o;
    logic           fpga_clk_en_o;
    logic           data_o;
    logic           core_ready_o;
    logic           locked_o;

    // Stimulus table and expected CRC per row
    pmu_pkg::word_t tbl_data  [NROWS][WORDS];
    pmu_pkg::word_t tbl_crc   [NROWS];
    logic           tbl_bad   [NROWS];
    logic           tbl_pause [NROWS];

    pmu_pkg::word_t nvm [2**pmu_pkg::ADDR_W];
    pmu_pkg::addr_t nvm_addr_s = '0;
    pmu_pkg::word_t nvm_wdata_s;
    logic           nvm_we_s = 1'b0;
    pmu_pkg::word_t nvm_rdata;

    logic        captured [$];  // data_o on each progclk pulse
    int          write_idx = 0;
    int          cur_row = 0;
    int unsigned errors = 0;
    int unsigned checks = 0;

    pmu_loader #(.WORDS(WORDS)) uut (
        .tck_i         (tck_i),
        .rst_i         (rst_i),
        .en_i          (en_i),
        .tdi_i         (tdi_i),
        .td_o          (td_o),
        .mem_data_i    (mem_data_i),
        .mem_data_o    (mem_data_o),
        .mem_address_o (mem_address_o),
        .mem_we_o      (mem_we_o),
        .progclk_o     (progclk_o),
        .preset_o      (preset_o),
        .fpga_rst_o    (fpga_rst_o),
        .fpga_clk_en_o (fpga_clk_en_o),
        .data_o        (data_o),
        .ccff_tail_i   (ccff_tail_i),
        .core_ready_o  (core_ready_o),
        .locked_o      (locked_o)
    );

    assign ccff_tail_i = data_o;  // Chain tail looped back

    initial begin
        tck_i = 1'b0;
        forever #(CLK_PERIOD / 2) tck_i = ~tck_i;
    end

    function automatic pmu_pkg::word_t fill_word(input pmu_pkg::addr_t a);
        return {~a, a ^ 8'h3C, a, 8'hA5 ^ a};
    endfunction

    // Reflected CRC-32 over one row LSB first
    function automatic pmu_pkg::word_t frame_crc(input int r);
        pmu_pkg::word_t crc;
        logic           fb;
        crc = pmu_pkg::CRC_INIT;
        for (int k = 0; k < WORDS; k++) begin
            for (int b = 0; b < pmu_pkg::WORD_W; b++) begin
                fb  = crc[0] ^ tbl_data[r][k][b];
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ pmu_pkg::CRC_POLY;
                end
            end
        end
        return crc ^ pmu_pkg::CRC_XOROUT;
    endfunction

    task automatic check_word(input string name, input pmu_pkg::word_t got,
                              input pmu_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input pmu_pkg::addr_t got,
                              input pmu_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic next_cycle();
        @(posedge tck_i);
        #1;
    endtask

    // NVM inputs sampled mid-cycle
    always @(negedge tck_i) begin
        nvm_addr_s  = mem_address_o;
        nvm_we_s    = mem_we_o;
        nvm_wdata_s = mem_data_o;
    end

    // NVM model refilled while in reset
    always @(posedge tck_i) begin
        if (rst_i) begin
            for (int a = 0; a < 2**pmu_pkg::ADDR_W; a++) begin
                nvm[a] = fill_word(pmu_pkg::addr_t'(a));
            end
        end
        nvm_rdata = nvm[nvm_addr_s];
        if (!rst_i && nvm_we_s) begin
            nvm[nvm_addr_s] = nvm_wdata_s;
        end
        #1;
        mem_data_i = nvm_rdata;
    end

    // Chain capture and write order check
    always @(negedge tck_i) begin
        if (rst_i) begin
            captured.delete();
            write_idx = 0;
        end else begin
            if (progclk_o === 1'b1) begin
                captured.push_back(data_o);
            end
            if (mem_we_o === 1'b1) begin
                if (write_idx < WORDS) begin
                    check_addr("mem_address_o", mem_address_o, pmu_pkg::addr_t'(write_idx));
                    check_word("mem_data_o", mem_data_o, tbl_data[cur_row][write_idx]);
                end else begin
                    report_failure($sformatf("row %0d: NVM write after the last data word",
                                             cur_row));
                end
                write_idx++;
            end
        end
    end

    task automatic build_table();
        for (int r = 0; r < NROWS; r++) begin
            for (int k = 0; k < WORDS; k++) begin
                case (r)
                    0, 5:    tbl_data[r][k] = '0;
                    1:       tbl_data[r][k] = '1;
                    2, 7:    tbl_data[r][k] = 32'h1 << (k * 8 + r);  // Walking one
                    default: tbl_data[r][k] = $urandom;
                endcase
            end
            tbl_bad[r]   = (r == 5 || r == 6);
            tbl_pause[r] = (r == 4 || r == 6 || r == 7);
            tbl_crc[r]   = frame_crc(r);
        end
    endtask

    task automatic apply_reset();
        rst_i = 1'b1;
        en_i  = 1'b0;
        tdi_i = 1'b0;
        repeat (4) next_cycle();
        rst_i = 1'b0;
    endtask

    task automatic check_reset_state();
        check_bit("mem_we_o", mem_we_o, 1'b0);
        check_bit("progclk_o", progclk_o, 1'b0);
        check_bit("data_o", data_o, 1'b0);
        check_bit("fpga_clk_en_o", fpga_clk_en_o, 1'b0);
        check_bit("core_ready_o", core_ready_o, 1'b0);
        check_bit("locked_o", locked_o, 1'b0);
        check_bit("td_o", td_o, 1'b0);
        check_bit("preset_o", preset_o, 1'b1);
        check_bit("fpga_rst_o", fpga_rst_o, 1'b1);
    endtask

    // LSB first with an optional gap mid-word
    task automatic send_word(input pmu_pkg::word_t w, input logic pause);
        for (int b = 0; b < pmu_pkg::WORD_W; b++) begin
            if (pause && b == 13) begin
                en_i = 1'b0;
                repeat (PAUSE_CYCLES) next_cycle();
            end
            en_i  = 1'b1;
            tdi_i = w[b];
            next_cycle();
        end
    endtask

    task automatic run_row(input int r);
        pmu_pkg::word_t checksum;
        cur_row = r;
        apply_reset();
        check_reset_state();
        for (int k = 0; k < WORDS; k++) begin
            send_word(tbl_data[r][k], tbl_pause[r]);
        end
        checksum = tbl_crc[r] ^ (tbl_bad[r] ? 32'h1 : 32'h0);
        send_word(checksum, tbl_pause[r]);
        en_i  = 1'b0;
        tdi_i = 1'b0;
        while (core_ready_o !== 1'b1 && locked_o !== 1'b1) begin
            next_cycle();
        end
        repeat (tbl_bad[r] ? 40 : 2) next_cycle();

        if (write_idx != WORDS) begin
            report_failure($sformatf("row %0d: %0d NVM writes instead of %0d",
                                     r, write_idx, WORDS));
        end
        for (int k = 0; k < WORDS; k++) begin
            check_word($sformatf("nvm[%0d]", k), nvm[k], tbl_data[r][k]);
        end

        if (tbl_bad[r]) begin
            check_bit("locked_o", locked_o, 1'b1);
            check_bit("core_ready_o", core_ready_o, 1'b0);
            check_bit("preset_o", preset_o, 1'b1);
            check_bit("fpga_rst_o", fpga_rst_o, 1'b1);
            check_bit("fpga_clk_en_o", fpga_clk_en_o, 1'b0);
            if (captured.size() != 0) begin
                report_failure($sformatf("row %0d: chain was clocked after a bad checksum", r));
            end
        end else begin
            check_bit("core_ready_o", core_ready_o, 1'b1);
            check_bit("fpga_clk_en_o", fpga_clk_en_o, 1'b1);
            check_bit("preset_o", preset_o, 1'b0);
            check_bit("fpga_rst_o", fpga_rst_o, 1'b0);
            check_bit("locked_o", locked_o, 1'b0);
            if (captured.size() != WORDS * pmu_pkg::WORD_W) begin
                report_failure($sformatf("row %0d: %0d chain bits captured instead of %0d",
                                         r, captured.size(), WORDS * pmu_pkg::WORD_W));
            end else begin
                for (int i = 0; i < WORDS * pmu_pkg::WORD_W; i++) begin
                    check_bit($sformatf("row %0d data_o bit %0d", r, i), captured[i],
                              tbl_data[r][i / pmu_pkg::WORD_W][i % pmu_pkg::WORD_W]);
                end
            end
            check_bit("td_o", td_o, tbl_data[r][WORDS-1][pmu_pkg::WORD_W-1]);
        end
    endtask

    initial begin
        rst_i = 1'b1;
        en_i  = 1'b0;
        tdi_i = 1'b0;
        void'($urandom(SEED));
        build_table();
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, uut.props_.assert_fails);
        if (errors == 0 && uut.props_.assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout after %0d ns, the DUT never finished a frame", LIMIT_NS);
        $display("tests failed");
        $finish;
    end

endmodule
